/* pipeline_cpu.f */
+incdir+.
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_cpu.sv
tb_pipeline_cpu.sv

/* Makefile */
# Verilator flow for pipeline_cpu

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f pipeline_cpu.f --top-module pipeline_cpu

sim:
	verilator --binary --timing -Wno-fatal -f pipeline_cpu.f \
		--top-module tb_pipeline_cpu -Mdir $(OBJ_DIR) -o tb_sim
	-./$(OBJ_DIR)/tb_sim 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_pipeline_cpu.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module tb_pipeline_cpu import cpu_pkg::*; ();

  localparam int prog_len        = 19;
  // two load-use pairs in the program below
  localparam int expected_stalls = 2;
  localparam int watchdog_cycles = 2 * prog_len + 20;
  localparam int tail_cycles     = 8;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic [`ADDR_WIDTH-1:0]     imem_addr;
  logic [`INST_WIDTH-1:0]     imem_data;
  logic                       wb_valid;
  logic [`REG_ADDR_WIDTH-1:0] wb_reg;
  logic [`DATA_WIDTH-1:0]     wb_data;

  logic [`INST_WIDTH-1:0]     prog_mem [prog_len];
  logic [`REG_ADDR_WIDTH-1:0] exp_reg_q [$];
  logic [`DATA_WIDTH-1:0]     exp_data_q [$];

  logic [`ADDR_WIDTH-1:0]     prev_addr;
  int                         pulses;
  int                         stalls;

  always #2 clk = ~clk;

  // rom beyond the table returns op_nop
  assign imem_data = (imem_addr < prog_len) ? prog_mem[imem_addr] : '0;

  pipeline_cpu dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

  //////////////////////////////
  // encoding and tables
  //////////////////////////////

  function automatic logic [`INST_WIDTH-1:0] r_type(input opcode_e op,
      input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic logic [`INST_WIDTH-1:0] i_type(input opcode_e op,
      input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic expect_write(input logic [4:0] r, input logic [31:0] value);
    exp_reg_q.push_back(r);
    exp_data_q.push_back(value);
  endtask

  task automatic load_tables();
    prog_mem[0]  = i_type(op_addi, 1, 0, 16'h0005);
    prog_mem[1]  = i_type(op_ori, 2, 0, 16'h00f0);
    // ex/mem into rt, mem/wb into rs
    prog_mem[2]  = r_type(op_add, 3, 1, 2);
    prog_mem[3]  = r_type(op_sub, 4, 3, 1);
    prog_mem[4]  = r_type(op_and, 5, 3, 4);
    prog_mem[5]  = r_type(op_or, 6, 1, 4);
    prog_mem[6]  = r_type(op_xor, 7, 6, 3);
    prog_mem[7]  = r_type(op_slt, 8, 1, 2);
    prog_mem[8]  = r_type(op_slt, 9, 2, 1);
    // store to word 8, then load it back
    prog_mem[9]  = i_type(op_sw, 2, 1, 16'h0003);
    prog_mem[10] = i_type(op_lw, 10, 0, 16'h0008);
    prog_mem[11] = r_type(op_add, 11, 10, 1);
    prog_mem[12] = i_type(op_addi, 0, 1, 16'h0007);
    prog_mem[13] = r_type(op_add, 12, 0, 1);
    prog_mem[14] = i_type(op_lw, 13, 1, 16'h0003);
    // load-use through rt
    prog_mem[15] = r_type(op_sub, 14, 1, 13);
    prog_mem[16] = r_type(op_xor, 0, 1, 2);
    prog_mem[17] = i_type(op_ori, 15, 0, 16'hbeef);
    prog_mem[18] = r_type(op_slt, 16, 14, 1);

    expect_write(1, 32'h0000_0005);
    expect_write(2, 32'h0000_00f0);
    expect_write(3, 32'h0000_00f5);
    expect_write(4, 32'h0000_00f0);
    expect_write(5, 32'h0000_00f0);
    expect_write(6, 32'h0000_00f5);
    expect_write(7, 32'h0000_0000);
    expect_write(8, 32'h0000_0001);
    expect_write(9, 32'h0000_0000);
    expect_write(10, 32'h0000_00f0);
    expect_write(11, 32'h0000_00f5);
    expect_write(12, 32'h0000_0005);
    expect_write(13, 32'h0000_00f0);
    expect_write(14, 32'hffff_ff15);
    expect_write(15, 32'h0000_beef);
    expect_write(16, 32'h0000_0001);
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
      input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // pc either holds for a stall or steps by one word
  task automatic track_fetch();
    if (imem_addr == prev_addr) begin
      stalls++;
    end else begin
      check_value("imem_addr", 32'(imem_addr), 32'(prev_addr) + 1);
    end
    prev_addr = imem_addr;
  endtask

  task automatic sample_writeback();
    if (wb_valid === 1'b1) begin
      if (pulses >= exp_reg_q.size()) begin
        $display("write-back pulse seen after the last expected one, at %0t ns", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "extra write-back");
      end else begin
        check_value("wb_reg", 32'(wb_reg), 32'(exp_reg_q[pulses]));
        check_value("wb_data", wb_data, exp_data_q[pulses]);
        pulses++;
      end
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("simulation ran out of time with %0d write-backs seen", pulses);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n  = 1'b0;
    pulses = 0;
    stalls = 0;
    load_tables();

    // first reset edge has been taken
    @(negedge clk);
    check_value("wb_valid", 32'(wb_valid), 32'd0);
    check_value("imem_addr", 32'(imem_addr), 32'd0);

    @(posedge clk);
    #1 rst_n = 1'b1;

    @(negedge clk);
    check_value("wb_valid", 32'(wb_valid), 32'd0);
    check_value("imem_addr", 32'(imem_addr), 32'd0);
    prev_addr = imem_addr;

    while (pulses < exp_reg_q.size()) begin
      @(negedge clk);
      track_fetch();
      sample_writeback();
    end

    // a few idle cycles to catch stray pulses
    repeat (tail_cycles) begin
      @(negedge clk);
      track_fetch();
      sample_writeback();
    end

    check_value("stall count", 32'(stalls), 32'(expected_stalls));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* pipeline_cpu.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module pipeline_cpu import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic [`ADDR_WIDTH-1:0]     imem_addr,
  input  logic [`INST_WIDTH-1:0]     imem_data,
  output logic                       wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  logic                       stall;
  instr_u                     if_instr;

  // id/ex
  alu_op_e                    ex_alu_op;
  logic [`REG_ADDR_WIDTH-1:0] ex_rs;
  logic [`REG_ADDR_WIDTH-1:0] ex_rt;
  logic [`REG_ADDR_WIDTH-1:0] ex_rd_dst;
  logic [`DATA_WIDTH-1:0]     ex_rs_data;
  logic [`DATA_WIDTH-1:0]     ex_rt_data;
  logic [`IMM_WIDTH-1:0]      ex_imm;
  logic                       ex_use_imm;
  logic                       ex_reg_write;
  logic                       ex_mem_read;
  logic                       ex_mem_write;

  // ex/mem
  logic [`DATA_WIDTH-1:0]     mem_alu_result;
  logic [`REG_ADDR_WIDTH-1:0] mem_dst;
  logic                       mem_reg_write;
  logic                       mem_mem_read;
  logic                       mem_mem_write;
  logic [`DATA_WIDTH-1:0]     mem_store_data;

  //////////////////////////////

  fetch_stage fetch0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .if_instr  (if_instr)
  );

  // write-back trace doubles as the register file write port
  decode_stage decode0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_instr     (if_instr),
    .wb_we        (wb_valid),
    .wb_addr      (wb_reg),
    .wb_data      (wb_data),
    .stall        (stall),
    .ex_alu_op    (ex_alu_op),
    .ex_rs        (ex_rs),
    .ex_rt        (ex_rt),
    .ex_rd_dst    (ex_rd_dst),
    .ex_rs_data   (ex_rs_data),
    .ex_rt_data   (ex_rt_data),
    .ex_imm       (ex_imm),
    .ex_use_imm   (ex_use_imm),
    .ex_reg_write (ex_reg_write),
    .ex_mem_read  (ex_mem_read),
    .ex_mem_write (ex_mem_write)
  );

  execute_stage execute0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_alu_op      (ex_alu_op),
    .ex_rs          (ex_rs),
    .ex_rt          (ex_rt),
    .ex_rd_dst      (ex_rd_dst),
    .ex_rs_data     (ex_rs_data),
    .ex_rt_data     (ex_rt_data),
    .ex_imm         (ex_imm),
    .ex_use_imm     (ex_use_imm),
    .ex_reg_write   (ex_reg_write),
    .ex_mem_read    (ex_mem_read),
    .ex_mem_write   (ex_mem_write),
    .mem_alu_result (mem_alu_result),
    .mem_dst        (mem_dst),
    .mem_reg_write  (mem_reg_write),
    .mem_mem_read   (mem_mem_read),
    .mem_mem_write  (mem_mem_write),
    .mem_store_data (mem_store_data),
    .wb_dst         (wb_reg),
    .wb_reg_write   (wb_valid),
    .wb_result      (wb_data)
  );

  memory_stage memory0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_alu_result (mem_alu_result),
    .mem_dst        (mem_dst),
    .mem_reg_write  (mem_reg_write),
    .mem_mem_read   (mem_mem_read),
    .mem_store_data (mem_store_data),
    .mem_write      (mem_mem_write),
    .wb_we          (wb_valid),
    .wb_addr        (wb_reg),
    .wb_data        (wb_data)
  );

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module memory_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`DATA_WIDTH-1:0]     mem_alu_result,
  input  logic [`REG_ADDR_WIDTH-1:0] mem_dst,
  input  logic                       mem_reg_write,
  input  logic                       mem_mem_read,
  input  logic [`DATA_WIDTH-1:0]     mem_store_data,
  input  logic                       mem_write,
  output logic                       wb_we,
  output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  localparam int unsigned dmem_idx_w = $clog2(`DMEM_WORDS);

  logic [`DATA_WIDTH-1:0] dmem [`DMEM_WORDS];
  logic [dmem_idx_w-1:0]  dmem_idx;
  logic [`DATA_WIDTH-1:0] load_data;

  // word index from the low alu bits
  assign dmem_idx  = mem_alu_result[dmem_idx_w-1:0];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (mem_write) begin
      dmem[dmem_idx] <= mem_store_data;
    end
  end

  // mem/wb, also the trace and the forwarding source
  always_ff @(posedge clk) begin
    wb_addr <= mem_dst;
    wb_data <= mem_mem_read ? load_data : mem_alu_result;
    if (!rst_n) begin
      wb_we <= 1'b0;
    end else begin
      wb_we <= mem_reg_write;
    end
  end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module execute_stage import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  alu_op_e                    ex_alu_op,
  input  logic [`REG_ADDR_WIDTH-1:0] ex_rs,
  input  logic [`REG_ADDR_WIDTH-1:0] ex_rt,
  input  logic [`REG_ADDR_WIDTH-1:0] ex_rd_dst,
  input  logic [`DATA_WIDTH-1:0]     ex_rs_data,
  input  logic [`DATA_WIDTH-1:0]     ex_rt_data,
  input  logic [`IMM_WIDTH-1:0]      ex_imm,
  input  logic                       ex_use_imm,
  input  logic                       ex_reg_write,
  input  logic                       ex_mem_read,
  input  logic                       ex_mem_write,
  output logic [`DATA_WIDTH-1:0]     mem_alu_result,
  output logic [`REG_ADDR_WIDTH-1:0] mem_dst,
  output logic                       mem_reg_write,
  output logic                       mem_mem_read,
  output logic                       mem_mem_write,
  output logic [`DATA_WIDTH-1:0]     mem_store_data,
  input  logic [`REG_ADDR_WIDTH-1:0] wb_dst,
  input  logic                       wb_reg_write,
  input  logic [`DATA_WIDTH-1:0]     wb_result
);

  fwd_sel_e               fwd_a;
  fwd_sel_e               fwd_b;
  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] rt_val;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] alu_result;

  //////////////////////////////
  // forwarding
  //////////////////////////////

  // ex/mem wins over mem/wb, a load in ex/mem is left to the stall
  function automatic fwd_sel_e pick_fwd(input logic [`REG_ADDR_WIDTH-1:0] src);
    if (src == '0) begin
      return fwd_none;
    end
    if (mem_reg_write && !mem_mem_read && mem_dst == src) begin
      return fwd_ex_mem;
    end
    if (wb_reg_write && wb_dst == src) begin
      return fwd_mem_wb;
    end
    return fwd_none;
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] fwd_mux(
    input fwd_sel_e               sel,
    input logic [`DATA_WIDTH-1:0] reg_val
  );
    case (sel)
      fwd_ex_mem: return mem_alu_result;
      fwd_mem_wb: return wb_result;
      default:    return reg_val;
    endcase
  endfunction

  always_comb begin
    fwd_a  = pick_fwd(ex_rs);
    fwd_b  = pick_fwd(ex_rt);
    op_a   = fwd_mux(fwd_a, ex_rs_data);
    rt_val = fwd_mux(fwd_b, ex_rt_data);
  end

  // immediate is zero extended
  assign op_b = ex_use_imm ? {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, ex_imm} : rt_val;

  //////////////////////////////
  // alu
  //////////////////////////////

  always_comb begin
    case (ex_alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = {{(`DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  // ex/mem
  always_ff @(posedge clk) begin
    mem_alu_result <= alu_result;
    mem_dst        <= ex_rd_dst;
    mem_store_data <= rt_val;
    if (!rst_n) begin
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
    end
  end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module decode_stage import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  instr_u                     if_instr,
  input  logic                       wb_we,
  input  logic [`REG_ADDR_WIDTH-1:0] wb_addr,
  input  logic [`DATA_WIDTH-1:0]     wb_data,
  output logic                       stall,
  output alu_op_e                    ex_alu_op,
  output logic [`REG_ADDR_WIDTH-1:0] ex_rs,
  output logic [`REG_ADDR_WIDTH-1:0] ex_rt,
  output logic [`REG_ADDR_WIDTH-1:0] ex_rd_dst,
  output logic [`DATA_WIDTH-1:0]     ex_rs_data,
  output logic [`DATA_WIDTH-1:0]     ex_rt_data,
  output logic [`IMM_WIDTH-1:0]      ex_imm,
  output logic                       ex_use_imm,
  output logic                       ex_reg_write,
  output logic                       ex_mem_read,
  output logic                       ex_mem_write
);

  opcode_e                    opcode;
  logic [`REG_ADDR_WIDTH-1:0] rs;
  logic [`REG_ADDR_WIDTH-1:0] rt;
  logic [`REG_ADDR_WIDTH-1:0] dst;
  logic [`DATA_WIDTH-1:0]     rs_data;
  logic [`DATA_WIDTH-1:0]     rt_data;
  logic                       is_r_type;
  alu_op_e                    alu_op;
  logic                       reg_write;
  logic                       mem_read;
  logic                       mem_write;

  //////////////////////////////
  // fields
  //////////////////////////////

  // opcode, rs and rt sit at the same bits in both formats
  assign opcode    = if_instr.r.opcode;
  assign rs        = if_instr.r.rs;
  assign rt        = if_instr.r.rt;
  assign is_r_type = opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_slt};
  assign dst       = is_r_type ? if_instr.r.rd : if_instr.i.rt;

  register_file regfile0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .we      (wb_we),
    .wr_addr (wb_addr),
    .wr_data (wb_data)
  );

  //////////////////////////////
  // control
  //////////////////////////////

  always_comb begin
    alu_op    = alu_add;
    reg_write = is_r_type;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (opcode)
      op_sub:  alu_op = alu_sub;
      op_and:  alu_op = alu_and;
      op_or:   alu_op = alu_or;
      op_xor:  alu_op = alu_xor;
      op_slt:  alu_op = alu_slt;
      op_addi: reg_write = 1'b1;
      op_ori: begin
        alu_op    = alu_or;
        reg_write = 1'b1;
      end
      op_lw: begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      op_sw:   mem_write = 1'b1;
      default: alu_op = alu_add;
    endcase
  end

  // load in ex feeding a source needed here, rt only counts for r-type and sw
  assign stall = ex_mem_read && ex_rt != '0 &&
                 (ex_rt == rs || (ex_rt == rt && (is_r_type || opcode == op_sw)));

  //////////////////////////////
  // id/ex
  //////////////////////////////

  always_ff @(posedge clk) begin
    ex_alu_op  <= alu_op;
    ex_rs      <= rs;
    ex_rt      <= rt;
    ex_rd_dst  <= dst;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
    ex_imm     <= if_instr.i.imm;
    ex_use_imm <= !is_r_type;
    if (!rst_n || stall) begin
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
    end else begin
      // writes to r0 are dropped here
      ex_reg_write <= reg_write && dst != '0;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
    end
  end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module register_file (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`REG_ADDR_WIDTH-1:0] rs_addr,
  input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
  output logic [`DATA_WIDTH-1:0]     rs_data,
  output logic [`DATA_WIDTH-1:0]     rt_data,
  input  logic                       we,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`DATA_WIDTH-1:0]     wr_data
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGISTERS];

  // r0 reads zero, a same-cycle write shows up on the read
  function automatic logic [`DATA_WIDTH-1:0] read_port(
    input logic [`REG_ADDR_WIDTH-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    if (we && addr == wr_addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGISTERS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

`include "cpu_macros.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  output logic [`ADDR_WIDTH-1:0] imem_addr,
  input  logic [`INST_WIDTH-1:0] imem_data,
  output instr_u                 if_instr
);

  logic [`ADDR_WIDTH-1:0] pc;

  // word addressed, the rom is read in the same cycle
  assign imem_addr = pc;

  // pc and if/id freeze together on a load-use stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      // all-zero word decodes as op_nop
      if_instr <= '0;
    end else if (!stall) begin
      pc       <= pc + 1'b1;
      if_instr <= imem_data;
    end
  end

endmodule

/* cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_addi = 6'd7,
    op_ori  = 6'd8,
    op_lw   = 6'd9,
    op_sw   = 6'd10
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5
  } alu_op_e;

  // register-register ops, rd is the target
  typedef struct packed {
    opcode_e                    opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [10:0]                unused;
  } r_fmt_t;

  // immediates, loads and stores
  typedef struct packed {
    opcode_e                    opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`IMM_WIDTH-1:0]      imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_e;

endpackage

/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath
`define DATA_WIDTH     32
`define INST_WIDTH     32

// word address for both instruction and data side
`define ADDR_WIDTH     16

// register file
`define REG_ADDR_WIDTH 5
`define NUM_REGISTERS  32

// i-format immediate, zero extended
`define IMM_WIDTH      16

// data ram depth in words
`define DMEM_WORDS     64

`endif
